/* global_buffer.f */
+incdir+design
design/glb_addr_pkg.sv
design/glb_cfg_pkg.sv
design/glb_bank.sv
design/glb_tile.sv
design/glb_cfg_ctrl.sv
design/global_buffer.sv
dv/tb_global_buffer.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_global_buffer -f global_buffer.f \
    && ./obj_dir/Vtb_global_buffer | tee /dev/stderr | grep -q "^Test OK$" \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

/* dv/tb_global_buffer.sv */
// global buffer testbench
`timescale 1ns/1ps
`include "glb_settings.svh"

module tb_global_buffer;

    import glb_addr_pkg::*;
    import glb_cfg_pkg::*;

    localparam int N     = `GLB_NUM_TILES;
    localparam int DW    = `GLB_DATA_WIDTH;
    localparam int BW    = `GLB_BANK_DEPTH_LOG2;
    localparam int TW    = `GLB_TILE_ID_WIDTH;
    localparam int AW    = GLB_ADDR_WIDTH;
    localparam int CW    = CFG_ADDR_WIDTH;
    localparam int SPACE = 1 << AW;

    // stream lengths per test
    localparam int LEN_OWN     = 8;
    localparam int LEN_CROSS   = 8;
    localparam int LEN_SPILL   = 8;
    localparam int LEN_RAND    = 12;
    localparam int TOTAL_WORDS = LEN_OWN + 2 * LEN_CROSS + LEN_SPILL + N * LEN_RAND;
    // watchdog limit in ns
    localparam int TIMEOUT_NS  = TOTAL_WORDS * N * 40 + 20000;

    // status register, all-ones tile id in register space
    localparam logic [CW-1:0] STATUS_ADDR = {CFG_SPACE_REG, {TW{1'b1}}, IRQ_STATUS};

    logic          clk;
    logic          rst;
    logic          cfg_valid;
    logic          cfg_ready;
    logic          cfg_write;
    glb_cfg_addr_u cfg_addr;
    logic [DW-1:0] cfg_wdata;
    logic          rsp_valid;
    logic          rsp_ready;
    logic [DW-1:0] rsp_data;
    logic          stream_valid [N];
    logic [DW-1:0] stream_data  [N];
    logic          stream_ready [N];
    logic          irq;

    // whole global address space
    logic [DW-1:0] ref_mem [SPACE];
    // expected responses in issue order
    logic [DW-1:0] exp_q [$];
    string         name_q [$];

    integer seed;
    int     errors;
    int     rsp_errors;
    int     rsp_count;
    int     streams_left;

    global_buffer dut0 (
        .clk,
        .rst,
        .cfg_valid,
        .cfg_ready,
        .cfg_write,
        .cfg_addr,
        .cfg_wdata,
        .rsp_valid,
        .rsp_ready,
        .rsp_data,
        .stream_valid,
        .stream_data,
        .stream_ready,
        .irq
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // word k of a stream, unique per test and tile
    function automatic logic [DW-1:0] stream_word(input int phase, input int t, input int k);
        return DW'((phase << 12) | (t << 8) | k);
    endfunction

    // expected word at a flat global address
    function automatic logic [DW-1:0] ref_read(input int g);
        return ref_mem[AW'(g)];
    endfunction

    function automatic logic [CW-1:0] reg_addr(input int t, input int idx);
        glb_cfg_addr_u a;
        a.fields.space   = CFG_SPACE_REG;
        a.fields.tile_id = TW'(t);
        a.fields.index   = BW'(idx);
        return a.raw;
    endfunction

    // memory space, low bits are the flat address
    function automatic logic [CW-1:0] mem_addr(input int g);
        return {CFG_SPACE_MEM, AW'(g)};
    endfunction

    // one host request, expected response queued for the checker
    task automatic cfg_send(input logic wr, input logic [CW-1:0] addr, input logic [DW-1:0] data,
                            input logic [DW-1:0] exp, input string name);
        @(negedge clk);
        cfg_valid    = 1'b1;
        cfg_write    = wr;
        cfg_addr.raw = addr;
        cfg_wdata    = data;
        exp_q.push_back(exp);
        name_q.push_back(name);
        // ready seen here means the handshake at the next rising edge
        while (!cfg_ready) @(negedge clk);
        @(negedge clk);
        cfg_valid = 1'b0;
    endtask

    task automatic cfg_wr(input logic [CW-1:0] addr, input logic [DW-1:0] data);
        cfg_send(1'b1, addr, data, '0, "write response");
    endtask

    task automatic cfg_rd(input logic [CW-1:0] addr, input logic [DW-1:0] exp, input string name);
        cfg_send(1'b0, addr, '0, exp, name);
    endtask

    // word k lands at raw start plus k
    task automatic program_tile(input int t, input int phase, input int start, input int count);
        int k;
        for (k = 0; k < count; k++) begin
            ref_mem[AW'((start + k) % SPACE)] = stream_word(phase, t, k);
        end
        cfg_wr(reg_addr(t, START_ADDR), DW'(start));
        cfg_wr(reg_addr(t, WORD_COUNT), DW'(count));
        cfg_wr(reg_addr(t, ARM), DW'(1));
    endtask

    task automatic stream_run(input int t, input int phase, input int count, input bit gaps);
        int k;
        int gap;
        @(negedge clk);
        for (k = 0; k < count; k++) begin
            if (gaps) begin
                gap = $random(seed) & 3;
                repeat (gap) @(negedge clk);
            end
            stream_valid[TW'(t)] = 1'b1;
            stream_data[TW'(t)]  = stream_word(phase, t, k);
            while (!stream_ready[TW'(t)]) @(negedge clk);
            @(negedge clk);
            stream_valid[TW'(t)] = 1'b0;
        end
        streams_left--;
    endtask

    // irq settles N+1 cycles after the last word
    task automatic irq_settle(input logic [N-1:0] mask);
        repeat (N) @(negedge clk);
        if (irq !== 1'b1) begin
            errors++;
            $display("error at time %0t: irq expected 1 got %b", $time, irq);
        end
        cfg_rd(STATUS_ADDR, DW'(mask), "IRQ_STATUS");
    endtask

    task automatic irq_clear(input logic [N-1:0] mask, input logic exp_irq);
        cfg_wr(STATUS_ADDR, DW'(mask));
        if (irq !== exp_irq) begin
            errors++;
            $display("error at time %0t: irq expected %b got %b", $time, exp_irq, irq);
        end
    endtask

    task automatic readback(input int start, input int count);
        int k;
        int g;
        for (k = 0; k < count; k++) begin
            g = (start + k) % SPACE;
            cfg_rd(mem_addr(g), ref_read(g), $sformatf("mem[%0d]", g));
        end
    endtask

    // response checker, random rsp_ready stalls
    initial begin
        logic          held;
        logic [DW-1:0] held_data;
        logic [DW-1:0] exp;
        string         name;
        rsp_ready = 1'b0;
        held      = 1'b0;
        held_data = '0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                // a stalled response must not move
                if (held && !rsp_valid) begin
                    rsp_errors++;
                    $display("error at time %0t: rsp_valid dropped before it was taken", $time);
                end else if (held && (rsp_data !== held_data)) begin
                    rsp_errors++;
                    $display("error at time %0t: rsp_data held expected %h got %h",
                             $time, held_data, rsp_data);
                end
                rsp_ready = (($random(seed) & 3) != 0);
                if (rsp_valid && rsp_ready) begin
                    held = 1'b0;
                    rsp_count++;
                    if (exp_q.size() == 0) begin
                        rsp_errors++;
                        $display("error at time %0t: response with no request outstanding",
                                 $time);
                    end else begin
                        exp  = exp_q.pop_front();
                        name = name_q.pop_front();
                        if (rsp_data !== exp) begin
                            rsp_errors++;
                            $display("error at time %0t: rsp_data for %s expected %h got %h",
                                     $time, name, exp, rsp_data);
                        end
                    end
                end else begin
                    held      = rsp_valid;
                    held_data = rsp_data;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the tests finished");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int i;
        seed         = 20;
        errors       = 0;
        rsp_errors   = 0;
        rsp_count    = 0;
        streams_left = 0;
        rst          = 1'b1;
        cfg_valid    = 1'b0;
        cfg_write    = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        for (i = 0; i < N; i++) begin
            stream_valid[TW'(i)] = 1'b0;
            stream_data[TW'(i)]  = '0;
        end
        for (i = 0; i < SPACE; i++) begin
            ref_mem[AW'(i)] = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // registers read back, unwritten memory reads zero
        cfg_wr(reg_addr(0, START_ADDR), DW'(677));
        cfg_wr(reg_addr(0, WORD_COUNT), 16'hbeef);
        cfg_wr(reg_addr(N - 1, START_ADDR), DW'(316));
        cfg_wr(reg_addr(N - 1, WORD_COUNT), 16'h0011);
        cfg_rd(reg_addr(0, START_ADDR), DW'(677), "tile 0 START_ADDR");
        cfg_rd(reg_addr(0, WORD_COUNT), 16'hbeef, "tile 0 WORD_COUNT");
        cfg_rd(reg_addr(N - 1, START_ADDR), DW'(316), "last tile START_ADDR");
        cfg_rd(reg_addr(N - 1, WORD_COUNT), 16'h0011, "last tile WORD_COUNT");
        cfg_rd(reg_addr(0, ARM), '0, "tile 0 ARM");
        cfg_rd(mem_addr(5), ref_read(5), "mem[5]");
        cfg_rd(mem_addr(900), ref_read(900), "mem[900]");

        // tile 1 into its own bank
        program_tile(1, 2, (1 << BW) + 10, LEN_OWN);
        streams_left = 1;
        stream_run(1, 2, LEN_OWN, 1'b0);
        irq_settle(4'b0010);
        irq_clear(4'b0010, 1'b0);
        readback((1 << BW) + 10, LEN_OWN);

        // first and last tile cross in both lanes
        program_tile(0, 3, (N - 1) * (1 << BW) + 64, LEN_CROSS);
        program_tile(N - 1, 3, 100, LEN_CROSS);
        streams_left = 2;
        fork
            stream_run(0, 3, LEN_CROSS, 1'b0);
            stream_run(N - 1, 3, LEN_CROSS, 1'b0);
        join
        // status bits clear one at a time
        irq_settle(4'b1001);
        irq_clear(4'b0001, 1'b1);
        cfg_rd(STATUS_ADDR, DW'(4'b1000), "IRQ_STATUS");
        irq_clear(4'b1000, 1'b0);
        readback((N - 1) * (1 << BW) + 64, LEN_CROSS);
        readback(100, LEN_CROSS);

        // tile 2 starts near its bank end and spills east
        program_tile(2, 4, 2 * (1 << BW) + 252, LEN_SPILL);
        streams_left = 1;
        stream_run(2, 4, LEN_SPILL, 1'b0);
        irq_settle(4'b0100);
        irq_clear(4'b0100, 1'b0);
        readback(2 * (1 << BW) + 252, LEN_SPILL);

        // every tile at once, two banks away, random gaps
        for (i = 0; i < N; i++) begin
            program_tile(i, 6, ((i + 2) % N) * (1 << BW) + 160, LEN_RAND);
        end
        streams_left = N;
        for (i = 0; i < N; i++) begin
            fork
                automatic int t = i;
                stream_run(t, 6, LEN_RAND, 1'b1);
            join_none
        end
        while (streams_left != 0) @(negedge clk);
        irq_settle(4'b1111);
        irq_clear(4'b1111, 1'b0);
        for (i = 0; i < N; i++) begin
            readback(i * (1 << BW) + 160, LEN_RAND);
        end

        // drain outstanding responses
        while (exp_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        $display("responses checked %0d, response errors %0d, other errors %0d",
                 rsp_count, rsp_errors, errors);
        if ((errors == 0) && (rsp_errors == 0)) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* design/global_buffer.sv */
// global buffer top level
`timescale 1ns/1ps
`include "glb_settings.svh"

module global_buffer (
    input  logic                         clk,
    input  logic                         rst,
    // host request
    input  logic                         cfg_valid,
    output logic                         cfg_ready,
    input  logic                         cfg_write,
    input  glb_cfg_pkg::glb_cfg_addr_u   cfg_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]   cfg_wdata,
    // host response
    output logic                         rsp_valid,
    input  logic                         rsp_ready,
    output logic [`GLB_DATA_WIDTH-1:0]   rsp_data,
    // fabric streams, one per tile
    input  logic                         stream_valid [`GLB_NUM_TILES],
    input  logic [`GLB_DATA_WIDTH-1:0]   stream_data  [`GLB_NUM_TILES],
    output logic                         stream_ready [`GLB_NUM_TILES],
    output logic                         irq
);

    import glb_addr_pkg::*;
    import glb_cfg_pkg::*;

    localparam int N = `GLB_NUM_TILES;

    // request chain, index i enters tile i
    logic                       req_valid [N+1];
    logic                       req_write [N+1];
    glb_cfg_addr_u              req_addr  [N+1];
    logic [`GLB_DATA_WIDTH-1:0] req_data  [N+1];
    // return chain, index i leaves tile i westward
    logic                       rtn_valid [N+1];
    logic [`GLB_DATA_WIDTH-1:0] rtn_data  [N+1];
    // eastbound lane, index i enters tile i
    logic                       e_valid [N+1];
    glb_addr_u                  e_addr  [N+1];
    logic [`GLB_DATA_WIDTH-1:0] e_data  [N+1];
    // westbound lane, index i+1 enters tile i
    logic                       w_valid [N+1];
    glb_addr_u                  w_addr  [N+1];
    logic [`GLB_DATA_WIDTH-1:0] w_data  [N+1];
    // interrupt vector, index i enters tile i
    logic [N-1:0]               irq_chain [N+1];

    // chain ends tied off
    assign rtn_valid[N]  = 1'b0;
    assign rtn_data[N]   = '0;
    assign e_valid[0]    = 1'b0;
    assign e_addr[0]     = '0;
    assign e_data[0]     = '0;
    assign w_valid[N]    = 1'b0;
    assign w_addr[N]     = '0;
    assign w_data[N]     = '0;
    assign irq_chain[0]  = '0;

    glb_cfg_ctrl ctrl0 (
        .clk,
        .rst,
        .cfg_valid,
        .cfg_ready,
        .cfg_write,
        .cfg_addr,
        .cfg_wdata,
        .rsp_valid,
        .rsp_ready,
        .rsp_data,
        .cfg_req_valid (req_valid[0]),
        .cfg_req_write (req_write[0]),
        .cfg_req_addr  (req_addr[0]),
        .cfg_req_data  (req_data[0]),
        .cfg_rtn_valid (rtn_valid[0]),
        .cfg_rtn_data  (rtn_data[0]),
        .irq_pulse     (irq_chain[N]),
        .irq
    );

    for (genvar i = 0; i < N; i++) begin : g_tile
        glb_tile #(
            .TILE_ID (i)
        ) tile (
            .clk               (clk),
            .rst               (rst),
            .cfg_req_valid     (req_valid[i]),
            .cfg_req_write     (req_write[i]),
            .cfg_req_addr      (req_addr[i]),
            .cfg_req_data      (req_data[i]),
            .cfg_req_out_valid (req_valid[i+1]),
            .cfg_req_out_write (req_write[i+1]),
            .cfg_req_out_addr  (req_addr[i+1]),
            .cfg_req_out_data  (req_data[i+1]),
            .cfg_rtn_in_valid  (rtn_valid[i+1]),
            .cfg_rtn_in_data   (rtn_data[i+1]),
            .cfg_rtn_out_valid (rtn_valid[i]),
            .cfg_rtn_out_data  (rtn_data[i]),
            .pkt_e_in_valid    (e_valid[i]),
            .pkt_e_in_addr     (e_addr[i]),
            .pkt_e_in_data     (e_data[i]),
            .pkt_e_out_valid   (e_valid[i+1]),
            .pkt_e_out_addr    (e_addr[i+1]),
            .pkt_e_out_data    (e_data[i+1]),
            .pkt_w_in_valid    (w_valid[i+1]),
            .pkt_w_in_addr     (w_addr[i+1]),
            .pkt_w_in_data     (w_data[i+1]),
            .pkt_w_out_valid   (w_valid[i]),
            .pkt_w_out_addr    (w_addr[i]),
            .pkt_w_out_data    (w_data[i]),
            .stream_valid      (stream_valid[i]),
            .stream_data       (stream_data[i]),
            .stream_ready      (stream_ready[i]),
            .irq_pulse_in      (irq_chain[i]),
            .irq_pulse_out     (irq_chain[i+1])
        );
    end

endmodule

/* design/glb_cfg_ctrl.sv */
// configuration controller
`timescale 1ns/1ps
`include "glb_settings.svh"

module glb_cfg_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    // host request
    input  logic                         cfg_valid,
    output logic                         cfg_ready,
    input  logic                         cfg_write,
    input  glb_cfg_pkg::glb_cfg_addr_u   cfg_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]   cfg_wdata,
    // host response
    output logic                         rsp_valid,
    input  logic                         rsp_ready,
    output logic [`GLB_DATA_WIDTH-1:0]   rsp_data,
    // request chain head
    output logic                         cfg_req_valid,
    output logic                         cfg_req_write,
    output glb_cfg_pkg::glb_cfg_addr_u   cfg_req_addr,
    output logic [`GLB_DATA_WIDTH-1:0]   cfg_req_data,
    // return chain tail
    input  logic                         cfg_rtn_valid,
    input  logic [`GLB_DATA_WIDTH-1:0]   cfg_rtn_data,
    // interrupt chain end
    input  logic [`GLB_NUM_TILES-1:0]    irq_pulse,
    output logic                         irq
);

    import glb_cfg_pkg::*;

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_WAIT_RTN = 2'd1;
    localparam logic [1:0] ST_HOLD_RSP = 2'd2;

    logic [1:0]                state;
    logic [`GLB_NUM_TILES-1:0] irq_status;
    logic [`GLB_NUM_TILES-1:0] clear_mask;
    logic                      host_acc;
    logic                      status_hit;

    assign host_acc   = cfg_valid && cfg_ready;
    // register space, all-ones tile id, status index
    assign status_hit = (cfg_addr.fields.space == CFG_SPACE_REG) &&
                        (&cfg_addr.fields.tile_id) &&
                        (cfg_addr.fields.index == IRQ_STATUS);
    // write 1 to clear
    assign clear_mask = (host_acc && status_hit && cfg_write) ?
                        cfg_wdata[`GLB_NUM_TILES-1:0] : '0;

    // sequencer, one request in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            cfg_ready     <= 1'b0;
            rsp_valid     <= 1'b0;
            cfg_req_valid <= 1'b0;
        end else begin
            // single cycle request pulse
            cfg_req_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    cfg_ready <= !host_acc;
                    if (host_acc && status_hit) begin
                        rsp_valid <= 1'b1;
                        state     <= ST_HOLD_RSP;
                    end else if (host_acc) begin
                        cfg_req_valid <= 1'b1;
                        state         <= ST_WAIT_RTN;
                    end
                end
                ST_WAIT_RTN: begin
                    if (cfg_rtn_valid) begin
                        rsp_valid <= 1'b1;
                        state     <= ST_HOLD_RSP;
                    end
                end
                ST_HOLD_RSP: begin
                    if (rsp_ready) begin
                        rsp_valid <= 1'b0;
                        cfg_ready <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (host_acc) begin
            cfg_req_write <= cfg_write;
            cfg_req_addr  <= cfg_addr;
            cfg_req_data  <= cfg_wdata;
            // status answered here, writes return zero
            rsp_data      <= cfg_write ? '0 : `GLB_DATA_WIDTH'(irq_status);
        end else if ((state == ST_WAIT_RTN) && cfg_rtn_valid) begin
            rsp_data <= cfg_rtn_data;
        end
    end

    // a new pulse beats a clear of the same bit
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_status <= '0;
        end else begin
            irq_status <= (irq_status & ~clear_mask) | irq_pulse;
        end
    end

    assign irq = |irq_status;

endmodule

/* design/glb_tile.sv */
// global buffer tile
`timescale 1ns/1ps
`include "glb_settings.svh"

module glb_tile #(
    parameter int TILE_ID = 0
) (
    input  logic                         clk,
    input  logic                         rst,
    // config requests from the west
    input  logic                         cfg_req_valid,
    input  logic                         cfg_req_write,
    input  glb_cfg_pkg::glb_cfg_addr_u   cfg_req_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]   cfg_req_data,
    // config requests to the east
    output logic                         cfg_req_out_valid,
    output logic                         cfg_req_out_write,
    output glb_cfg_pkg::glb_cfg_addr_u   cfg_req_out_addr,
    output logic [`GLB_DATA_WIDTH-1:0]   cfg_req_out_data,
    // config returns, east in and west out
    input  logic                         cfg_rtn_in_valid,
    input  logic [`GLB_DATA_WIDTH-1:0]   cfg_rtn_in_data,
    output logic                         cfg_rtn_out_valid,
    output logic [`GLB_DATA_WIDTH-1:0]   cfg_rtn_out_data,
    // eastbound lane
    input  logic                         pkt_e_in_valid,
    input  glb_addr_pkg::glb_addr_u      pkt_e_in_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]   pkt_e_in_data,
    output logic                         pkt_e_out_valid,
    output glb_addr_pkg::glb_addr_u      pkt_e_out_addr,
    output logic [`GLB_DATA_WIDTH-1:0]   pkt_e_out_data,
    // westbound lane
    input  logic                         pkt_w_in_valid,
    input  glb_addr_pkg::glb_addr_u      pkt_w_in_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]   pkt_w_in_data,
    output logic                         pkt_w_out_valid,
    output glb_addr_pkg::glb_addr_u      pkt_w_out_addr,
    output logic [`GLB_DATA_WIDTH-1:0]   pkt_w_out_data,
    // fabric stream
    input  logic                         stream_valid,
    input  logic [`GLB_DATA_WIDTH-1:0]   stream_data,
    output logic                         stream_ready,
    // interrupt chain, west to east
    input  logic [`GLB_NUM_TILES-1:0]    irq_pulse_in,
    output logic [`GLB_NUM_TILES-1:0]    irq_pulse_out
);

    import glb_addr_pkg::*;
    import glb_cfg_pkg::*;

    localparam logic [`GLB_TILE_ID_WIDTH-1:0] MY_ID = `GLB_TILE_ID_WIDTH'(TILE_ID);

    // config registers and stream counters
    glb_addr_u                  start_addr;
    logic [`GLB_DATA_WIDTH-1:0] word_count;
    logic                       armed;
    glb_addr_u                  addr_cnt;
    logic [`GLB_DATA_WIDTH-1:0] words_left;

    logic                       cfg_hit;
    logic                       reg_wr;
    logic                       mem_rd;
    logic                       mem_rsp_pend;
    logic [`GLB_DATA_WIDTH-1:0] reg_rd_data;
    logic [`GLB_DATA_WIDTH-1:0] bank_rd_data;

    // own packet stage between stream and lanes
    logic                       own_valid;
    glb_addr_u                  own_addr;
    logic [`GLB_DATA_WIDTH-1:0] own_data;
    logic                       own_local;
    logic                       own_east;
    logic                       own_go;

    logic                       e_here;
    logic                       e_thru;
    logic                       w_here;
    logic                       w_thru;
    logic                       stream_accept;
    logic                       last_acc;
    // last word flag delayed TILE_ID cycles
    logic                       own_done;

    // config decode
    assign cfg_hit = cfg_req_valid && (cfg_req_addr.fields.tile_id == MY_ID);
    assign reg_wr  = cfg_hit && cfg_req_write && (cfg_req_addr.fields.space == CFG_SPACE_REG);
    // memory space is read only from the host
    assign mem_rd  = cfg_hit && !cfg_req_write && (cfg_req_addr.fields.space == CFG_SPACE_MEM);

    always_comb begin
        reg_rd_data = '0;
        if (!cfg_req_write && (cfg_req_addr.fields.space == CFG_SPACE_REG)) begin
            case (cfg_req_addr.fields.index)
                START_ADDR: reg_rd_data = `GLB_DATA_WIDTH'(start_addr.raw);
                WORD_COUNT: reg_rd_data = word_count;
                ARM:        reg_rd_data = `GLB_DATA_WIDTH'(armed);
                default:    reg_rd_data = '0;
            endcase
        end
    end

    // pass misses east, one hop per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_req_out_valid <= 1'b0;
        end else begin
            cfg_req_out_valid <= cfg_req_valid && !cfg_hit;
        end
    end

    always_ff @(posedge clk) begin
        cfg_req_out_write <= cfg_req_write;
        cfg_req_out_addr  <= cfg_req_addr;
        cfg_req_out_data  <= cfg_req_data;
    end

    // return merge, through traffic first
    // one request in flight so sources never collide
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_rtn_out_valid <= 1'b0;
            mem_rsp_pend      <= 1'b0;
        end else begin
            cfg_rtn_out_valid <= cfg_rtn_in_valid || mem_rsp_pend || (cfg_hit && !mem_rd);
            mem_rsp_pend      <= mem_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_rtn_in_valid) begin
            cfg_rtn_out_data <= cfg_rtn_in_data;
        end else if (mem_rsp_pend) begin
            cfg_rtn_out_data <= bank_rd_data;
        end else begin
            cfg_rtn_out_data <= reg_rd_data;
        end
    end

    // stream side
    assign stream_accept = stream_valid && stream_ready;
    assign last_acc      = stream_accept && (words_left == `GLB_DATA_WIDTH'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            start_addr <= '0;
            word_count <= '0;
            armed      <= 1'b0;
        end else if (reg_wr) begin
            case (cfg_req_addr.fields.index)
                START_ADDR: start_addr.raw <= cfg_req_data[GLB_ADDR_WIDTH-1:0];
                WORD_COUNT: word_count <= cfg_req_data;
                ARM:        armed <= (word_count != '0);
                default:    armed <= armed;
            endcase
        end else if (last_acc) begin
            armed <= 1'b0;
        end
    end

    // arm loads counters, raw count crosses into next tile
    always_ff @(posedge clk) begin
        if (reg_wr && (cfg_req_addr.fields.index == ARM)) begin
            addr_cnt   <= start_addr;
            words_left <= word_count;
        end else if (stream_accept) begin
            addr_cnt.raw <= addr_cnt.raw + 1'b1;
            words_left   <= words_left - 1'b1;
        end
    end

    // packet routing
    assign e_here    = pkt_e_in_valid && (pkt_e_in_addr.fields.tile_id == MY_ID);
    assign e_thru    = pkt_e_in_valid && !e_here;
    assign w_here    = pkt_w_in_valid && (pkt_w_in_addr.fields.tile_id == MY_ID);
    assign w_thru    = pkt_w_in_valid && !w_here;
    assign own_local = (own_addr.fields.tile_id == MY_ID);
    assign own_east  = (own_addr.fields.tile_id > MY_ID);

    // own packet yields to arrivals on port a and to through packets
    assign own_go = own_valid && ((own_local && !e_here) ||
                                  (own_east && !e_thru) ||
                                  (!own_local && !own_east && !w_thru));

    assign stream_ready = armed && (!own_valid || own_go);

    always_ff @(posedge clk) begin
        if (rst) begin
            own_valid <= 1'b0;
        end else if (stream_accept) begin
            own_valid <= 1'b1;
        end else if (own_go) begin
            own_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (stream_accept) begin
            own_addr <= addr_cnt;
            own_data <= stream_data;
        end
    end

    // lane output registers
    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_e_out_valid <= 1'b0;
            pkt_w_out_valid <= 1'b0;
        end else begin
            pkt_e_out_valid <= e_thru || (own_go && own_east);
            pkt_w_out_valid <= w_thru || (own_go && !own_local && !own_east);
        end
    end

    always_ff @(posedge clk) begin
        pkt_e_out_addr <= e_thru ? pkt_e_in_addr : own_addr;
        pkt_e_out_data <= e_thru ? pkt_e_in_data : own_data;
        pkt_w_out_addr <= w_thru ? pkt_w_in_addr : own_addr;
        pkt_w_out_data <= w_thru ? pkt_w_in_data : own_data;
    end

    // port a takes eastbound arrivals or own packets, port b westbound
    glb_bank #(
        .DEPTH_LOG2 (`GLB_BANK_DEPTH_LOG2),
        .WIDTH      (`GLB_DATA_WIDTH)
    ) bank0 (
        .clk     (clk),
        .rst     (rst),
        .wa_en   (e_here || (own_go && own_local)),
        .wa_addr (e_here ? pkt_e_in_addr.fields.offset : own_addr.fields.offset),
        .wa_data (e_here ? pkt_e_in_data : own_data),
        .wb_en   (w_here),
        .wb_addr (pkt_w_in_addr.fields.offset),
        .wb_data (pkt_w_in_data),
        .rd_en   (mem_rd),
        .rd_addr (cfg_req_addr.fields.index),
        .rd_data (bank_rd_data)
    );

    // interrupt hop
    // own bit waits TILE_ID cycles so every tile sees the same latency
    if (TILE_ID == 0) begin : g_done_now
        assign own_done = last_acc;
    end else begin : g_done_dly
        // done delay line
        logic [TILE_ID-1:0] done_sr;
        always_ff @(posedge clk) begin
            if (rst) begin
                done_sr <= '0;
            end else begin
                done_sr <= TILE_ID'({done_sr, last_acc});
            end
        end
        assign own_done = done_sr[TILE_ID-1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_pulse_out <= '0;
        end else begin
            irq_pulse_out <= irq_pulse_in | (`GLB_NUM_TILES'(own_done) << TILE_ID);
        end
    end

endmodule

/* design/glb_bank.sv */
// tile memory bank
`timescale 1ns/1ps

module glb_bank #(
    parameter int DEPTH_LOG2 = 8,
    parameter int WIDTH      = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wa_en,
    input  logic [DEPTH_LOG2-1:0] wa_addr,
    input  logic [WIDTH-1:0]      wa_data,
    input  logic                  wb_en,
    input  logic [DEPTH_LOG2-1:0] wb_addr,
    input  logic [WIDTH-1:0]      wb_data,
    input  logic                  rd_en,
    input  logic [DEPTH_LOG2-1:0] rd_addr,
    output logic [WIDTH-1:0]      rd_data
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0] mem [DEPTH];
    // per word written flag, unwritten words read as zero
    logic [DEPTH-1:0] written;

    always_ff @(posedge clk) begin
        if (wa_en) begin
            mem[wa_addr] <= wa_data;
        end
        // port b last, so it wins on the same word
        if (wb_en) begin
            mem[wb_addr] <= wb_data;
        end
        // registered read, holds when idle
        if (rd_en) begin
            rd_data <= written[rd_addr] ? mem[rd_addr] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            written <= '0;
        end else begin
            if (wa_en) begin
                written[wa_addr] <= 1'b1;
            end
            if (wb_en) begin
                written[wb_addr] <= 1'b1;
            end
        end
    end

endmodule

/* design/glb_cfg_pkg.sv */
// configuration address types
`include "glb_settings.svh"

package glb_cfg_pkg;

    // space bit values
    localparam logic CFG_SPACE_REG = 1'b0;
    localparam logic CFG_SPACE_MEM = 1'b1;

    // space bit, tile id, then shared index or offset bits
    localparam int CFG_ADDR_WIDTH = 1 + `GLB_TILE_ID_WIDTH + `GLB_BANK_DEPTH_LOG2;

    // register index names
    // IRQ_STATUS lives in the controller, reached with the all-ones tile id
    typedef enum logic [`GLB_BANK_DEPTH_LOG2-1:0] {
        START_ADDR,
        WORD_COUNT,
        ARM,
        IRQ_STATUS
    } glb_cfg_reg_e;

    typedef struct packed {
        logic                            space;
        logic [`GLB_TILE_ID_WIDTH-1:0]   tile_id;
        logic [`GLB_BANK_DEPTH_LOG2-1:0] index;
    } glb_cfg_addr_fields_t;

    typedef union packed {
        logic [CFG_ADDR_WIDTH-1:0] raw;
        glb_cfg_addr_fields_t      fields;
    } glb_cfg_addr_u;

endpackage

/* design/glb_addr_pkg.sv */
// global memory address types
`include "glb_settings.svh"

package glb_addr_pkg;

    // flat address is tile id over bank offset
    localparam int GLB_ADDR_WIDTH = `GLB_TILE_ID_WIDTH + `GLB_BANK_DEPTH_LOG2;

    typedef struct packed {
        logic [`GLB_TILE_ID_WIDTH-1:0]   tile_id;
        logic [`GLB_BANK_DEPTH_LOG2-1:0] offset;
    } glb_addr_fields_t;

    // raw view counts across tiles, fields view routes and indexes
    typedef union packed {
        logic [GLB_ADDR_WIDTH-1:0] raw;
        glb_addr_fields_t          fields;
    } glb_addr_u;

endpackage

/* design/glb_settings.svh */
// global buffer build settings
`ifndef GLB_SETTINGS_SVH
`define GLB_SETTINGS_SVH

// number of tiles in the chain
`define GLB_NUM_TILES 4

// stream and memory word width
`define GLB_DATA_WIDTH 16

// words per bank, as log2
`define GLB_BANK_DEPTH_LOG2 8

// bits needed for a tile id
`define GLB_TILE_ID_WIDTH 2

`endif
